// ==== frontEnd_config.svh ====
// sizing macros for the front end: bundle, dispatch, queue and decoded field widths.
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// fetch and dispatch group sizes.
`define FETCH_WIDTH      4   // words per bundle.
`define DISPATCH_WIDTH   2   // packets per group.

// instruction queue, depth is a power of two.
`define INST_QUEUE       16
`define INST_QUEUE_LOG   4   // head/tail width.

// raw word and address widths.
`define SIZE_PC          32
`define SIZE_INST        32

// decoded field sizes.
`define SIZE_OPCODE      4   // raw opcode nibble.
`define SIZE_RMT_LOG     5   // arch register index.
`define SIZE_IMMEDIATE   16
`define BRANCH_CNT_W     2   // holds 0..DISPATCH_WIDTH.

// pc, opcode, isCti, dest/src1/src2, imm.
`define DECODED_WIDTH    (`SIZE_PC + `SIZE_OPCODE + 1 + 3*`SIZE_RMT_LOG + `SIZE_IMMEDIATE)

`endif

// ==== frontEndPkg.sv ====
// opcode enum, decoded instruction struct and branch count type.
`default_nettype none

`include "frontEnd_config.svh"

package frontEndPkg;

  // raw values 0..6 map in order, anything above is illegal.
  typedef enum logic [`SIZE_OPCODE-1:0] {
    opAlu     = 4'd0,
    opAddi    = 4'd1,
    opLoad    = 4'd2,
    opStore   = 4'd3,
    opBranch  = 4'd4,
    opJump    = 4'd5,
    opNop     = 4'd6,
    opIllegal = 4'd7
  } opcode_e;

  // one decoded packet, msb first.
  typedef struct packed {
    logic [`SIZE_PC-1:0]        pc;      // lane pc.
    opcode_e                    opcode;
    logic                       isCti;   // branch or jump.
    logic [`SIZE_RMT_LOG-1:0]   dest;
    logic [`SIZE_RMT_LOG-1:0]   src1;
    logic [`SIZE_RMT_LOG-1:0]   src2;
    logic [`SIZE_IMMEDIATE-1:0] imm;     // sign extended.
  } decodedInst_t;

  // number of control transfers in a dispatch group.
  typedef logic [`BRANCH_CNT_W-1:0] branchCnt_t;

endpackage

`default_nettype wire

// ==== multiPortRam.sv ====
// register array with four write ports and two async read ports.
`default_nettype none
`timescale 1ns/1ps

module multiPortRam #(
  parameter int DEPTH  = 16,
  parameter int ADDR_W = 4,
  parameter int DATA_W = 68
) (
  input  logic                               clk,

  // one write port per fetch lane.
  input  logic [3:0]                         we_i,
  input  logic [3:0][ADDR_W-1:0]             waddr_i,
  input  logic [3:0][DATA_W-1:0]             wdata_i,

  // one read port per dispatch slot.
  input  logic [1:0][ADDR_W-1:0]             raddr_i,
  output logic [1:0][DATA_W-1:0]             rdata_o
);

  localparam int WR_PORTS = 4;
  localparam int RD_PORTS = 2;

  logic [DATA_W-1:0] mem [DEPTH];   // entry storage.

  // writes land on the edge.
  // the last port wins when two addresses collide.
  always_ff @(posedge clk) begin
    for (int p = 0; p < WR_PORTS; p++) begin
      if (we_i[p]) begin
        mem[waddr_i[p]] <= wdata_i[p];
      end
    end
  end

  // combinational reads without bypass from same-edge writes.
  always_comb begin
    for (int p = 0; p < RD_PORTS; p++) begin
      rdata_o[p] = mem[raddr_i[p]];
    end
  end

endmodule

`default_nettype wire

// ==== instDecoder.sv ====
// one registered decode stage for a four-lane fetch bundle.
`default_nettype none
`timescale 1ns/1ps

`include "frontEnd_config.svh"

module instDecoder import frontEndPkg::*; (
  input  logic                                  clk,
  input  logic                                  arstN_i,
  input  logic                                  flush_i,        // sync clear of the stage.

  // fetch side.
  input  logic                                  fetchValid_i,
  input  logic [`FETCH_WIDTH-1:0]               fetchMask_i,    // per lane valid.
  input  logic [`SIZE_PC-1:0]                   fetchPc_i,      // pc of lane 0.
  input  logic [`FETCH_WIDTH-1:0][`SIZE_INST-1:0] fetchInst_i,
  output logic                                  fetchReady_o,

  // buffer side.
  input  logic                                  decAccept_i,
  output logic                                  decValid_o,
  output logic [`FETCH_WIDTH-1:0]               decMask_o,
  output decodedInst_t [`FETCH_WIDTH-1:0]       decInst_o
);

  logic                                stageValid;  // stage holds a bundle.
  logic [`FETCH_WIDTH-1:0]             stageMask;
  decodedInst_t [`FETCH_WIDTH-1:0]     stageInst;
  decodedInst_t [`FETCH_WIDTH-1:0]     laneDec;     // combinational decode.
  logic                                loadStage;

  // splits one raw word into its fields.
  function automatic decodedInst_t decodeWord(
    input logic [`SIZE_INST-1:0] word,
    input logic [`SIZE_PC-1:0]   pc
  );
    decodedInst_t            d;
    logic [`SIZE_OPCODE-1:0] rawOp;

    rawOp = word[31:28];
    d.pc  = pc;
    if (rawOp <= 4'd6) begin
      d.opcode = opcode_e'(rawOp);
    end else begin
      d.opcode = opIllegal;              // 7..15 unknown.
    end
    d.isCti = (d.opcode == opBranch) || (d.opcode == opJump);
    d.dest  = word[27:23];
    d.src1  = word[22:18];
    d.src2  = word[17:13];
    d.imm   = signed'(word[15:0]);       // overlaps src2.
    return d;
  endfunction

  // lane k sits at pc + 4k.
  always_comb begin
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      laneDec[k] = decodeWord(fetchInst_i[k], fetchPc_i + `SIZE_PC'(4 * k));
    end
  end

  // free stage, or its bundle leaves this edge.
  assign fetchReady_o = ~stageValid | decAccept_i;
  assign loadStage    = fetchValid_i & fetchReady_o & ~flush_i;  // flush drops it.

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      stageValid <= 1'b0;
    end else if (flush_i) begin
      stageValid <= 1'b0;
    end else if (loadStage) begin
      stageValid <= 1'b1;                // back to back bundles.
    end else if (decAccept_i) begin
      stageValid <= 1'b0;                // drained with nothing new.
    end
  end

  // payload only moves on a new bundle, so it holds while refused.
  always_ff @(posedge clk) begin
    if (loadStage) begin
      stageMask <= fetchMask_i;
      stageInst <= laneDec;
    end
  end

  assign decValid_o = stageValid;
  assign decMask_o  = stageMask;
  assign decInst_o  = stageInst;

endmodule

`default_nettype wire

// ==== instBuffer.sv ====
// circular decoded-instruction queue with compacting writes and group dispatch.
`default_nettype none
`timescale 1ns/1ps

`include "frontEnd_config.svh"

module instBuffer import frontEndPkg::*; (
  input  logic                                 clk,
  input  logic                                 arstN_i,
  input  logic                                 flush_i,        // sync clear of pointers.

  // decoder side.
  input  logic                                 decValid_i,
  input  logic [`FETCH_WIDTH-1:0]              decMask_i,
  input  decodedInst_t [`FETCH_WIDTH-1:0]      decInst_i,
  output logic                                 decAccept_o,

  // rename side.
  input  logic                                 dispatchStall_i,
  output logic                                 dispatchReady_o,
  output decodedInst_t [`DISPATCH_WIDTH-1:0]   dispatchInst_o,
  output branchCnt_t                           branchCount_o
);

  localparam int ADDR_W     = `INST_QUEUE_LOG;
  localparam int CNT_W      = `INST_QUEUE_LOG + 1;       // 0..INST_QUEUE.
  localparam int LANE_CNT_W = $clog2(`FETCH_WIDTH + 1);  // 0..FETCH_WIDTH.

  logic [ADDR_W-1:0]                      headPtr;    // oldest packet.
  logic [ADDR_W-1:0]                      tailPtr;    // next free slot.
  logic [CNT_W-1:0]                       instCount;  // live packets.
  logic [CNT_W-1:0]                       countNext;

  logic                                   doWrite;
  logic                                   doDispatch;
  logic [`FETCH_WIDTH-1:0]                writeEn;
  logic [`FETCH_WIDTH-1:0][ADDR_W-1:0]    writeAddr;
  logic [LANE_CNT_W-1:0]                  prefixCnt;  // valid lanes seen so far.
  logic [LANE_CNT_W-1:0]                  writeCnt;
  logic [`DISPATCH_WIDTH-1:0][ADDR_W-1:0] readAddr;

  // room for a whole bundle whatever its mask.
  assign decAccept_o = instCount <= CNT_W'(`INST_QUEUE - `FETCH_WIDTH);
  assign doWrite     = decValid_i & decAccept_o;

  // nothing leaves on a flush edge.
  assign dispatchReady_o = (instCount >= CNT_W'(`DISPATCH_WIDTH)) & ~flush_i;
  assign doDispatch      = dispatchReady_o & ~dispatchStall_i;

  // lane k goes to tail + number of valid lanes below it.
  // masked lanes are skipped, so holes are squeezed out.
  always_comb begin
    prefixCnt = '0;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      writeEn[k]   = doWrite & decMask_i[k];
      writeAddr[k] = tailPtr + ADDR_W'(prefixCnt);
      if (decMask_i[k]) begin
        prefixCnt = prefixCnt + 1'b1;
      end
    end
    writeCnt = doWrite ? prefixCnt : '0;
  end

  // read window at head.
  always_comb begin
    for (int r = 0; r < `DISPATCH_WIDTH; r++) begin
      readAddr[r] = headPtr + ADDR_W'(r);
    end
  end

  multiPortRam #(
    .DEPTH  (`INST_QUEUE),
    .ADDR_W (ADDR_W),
    .DATA_W (`DECODED_WIDTH)
  ) queueRam (
    .clk     (clk),
    .we_i    (writeEn),
    .waddr_i (writeAddr),
    .wdata_i (decInst_i),
    .raddr_i (readAddr),
    .rdata_o (dispatchInst_o)
  );

  // written lanes in and a full group out.
  always_comb begin
    countNext = instCount + CNT_W'(writeCnt);
    if (doDispatch) begin
      countNext = countNext - CNT_W'(`DISPATCH_WIDTH);
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else if (flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      if (doDispatch) begin
        headPtr <= headPtr + ADDR_W'(`DISPATCH_WIDTH);  // wraps at depth.
      end
      tailPtr   <= tailPtr + ADDR_W'(writeCnt);
      instCount <= countNext;
    end
  end

  // add up the cti bits of the group.
  always_comb begin
    branchCount_o = '0;
    for (int r = 0; r < `DISPATCH_WIDTH; r++) begin
      branchCount_o = branchCount_o + branchCnt_t'(dispatchInst_o[r].isCti);
    end
  end

endmodule

`default_nettype wire

// ==== frontEndTop.sv ====
// top level with the decode stage feeding the instruction buffer.
`default_nettype none
`timescale 1ns/1ps

`include "frontEnd_config.svh"

module frontEndTop import frontEndPkg::*; (
  input  logic                                    clk,
  input  logic                                    arstN_i,
  input  logic                                    flush_i,

  // fetch bundle.
  input  logic                                    fetchValid_i,
  input  logic [`FETCH_WIDTH-1:0]                 fetchMask_i,
  input  logic [`SIZE_PC-1:0]                     fetchPc_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_INST-1:0] fetchInst_i,
  output logic                                    fetchReady_o,

  // dispatch group.
  input  logic                                    dispatchStall_i,
  output logic                                    dispatchReady_o,
  output decodedInst_t [`DISPATCH_WIDTH-1:0]      dispatchInst_o,
  output branchCnt_t                              branchCount_o
);

  logic                            decValid;   // stage register full.
  logic                            decAccept;  // queue has room.
  logic [`FETCH_WIDTH-1:0]         decMask;
  decodedInst_t [`FETCH_WIDTH-1:0] decInst;

  instDecoder decoder (
    .clk          (clk),
    .arstN_i      (arstN_i),
    .flush_i      (flush_i),
    .fetchValid_i (fetchValid_i),
    .fetchMask_i  (fetchMask_i),
    .fetchPc_i    (fetchPc_i),
    .fetchInst_i  (fetchInst_i),
    .fetchReady_o (fetchReady_o),
    .decAccept_i  (decAccept),
    .decValid_o   (decValid),
    .decMask_o    (decMask),
    .decInst_o    (decInst)
  );

  instBuffer buffer (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .flush_i         (flush_i),
    .decValid_i      (decValid),
    .decMask_i       (decMask),
    .decInst_i       (decInst),
    .decAccept_o     (decAccept),
    .dispatchStall_i (dispatchStall_i),
    .dispatchReady_o (dispatchReady_o),
    .dispatchInst_o  (dispatchInst_o),
    .branchCount_o   (branchCount_o)
  );

endmodule

`default_nettype wire

// ==== tb_frontEnd.sv ====
// file driven testbench for the decode stage and instruction buffer.
`default_nettype none
`timescale 1ns/1ps

`include "frontEnd_config.svh"

module tb_frontEnd import frontEndPkg::*; ;

  localparam int MAX_LINES = 64;

  logic                                    clk;
  logic                                    arstN_i;
  logic                                    flush_i;
  logic                                    fetchValid_i;
  logic [`FETCH_WIDTH-1:0]                 fetchMask_i;
  logic [`SIZE_PC-1:0]                     fetchPc_i;
  logic [`FETCH_WIDTH-1:0][`SIZE_INST-1:0] fetchInst_i;
  logic                                    fetchReady_o;
  logic                                    dispatchStall_i;
  logic                                    dispatchReady_o;
  decodedInst_t [`DISPATCH_WIDTH-1:0]      dispatchInst_o;
  branchCnt_t                              branchCount_o;

  // bundle lines hold mask, pc, words, stall cycles, flush, random stall and idle gap.
  logic [31:0] bMask [MAX_LINES];
  logic [31:0] bPc [MAX_LINES];
  logic [31:0] bWord [MAX_LINES][4];
  logic [31:0] bStall [MAX_LINES];
  logic [31:0] bFlush [MAX_LINES];
  logic [31:0] bRnd [MAX_LINES];
  logic [31:0] bGap [MAX_LINES];
  // expected groups hold 7 fields per slot and the branch count.
  logic [31:0] eField [MAX_LINES][15];

  integer numLines;
  integer numExp;
  integer lineIdx;
  integer expIdx;
  integer gapLeft;
  integer stallLeft;
  integer cycles;
  integer limit;
  integer seed;
  integer fd;
  integer code;
  logic   lineActive;   // a bundle line is on the inputs.
  logic   stallLoaded;  // its stall window already started.
  logic   rndNow;
  logic   sawBlock;     // fetchReady_o seen low.
  logic   flushPending;
  logic   running;
  logic [7:0]       kind;
  logic [8*200-1:0] skipLine;
  decodedInst_t     got;

  frontEndTop dut (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .flush_i         (flush_i),
    .fetchValid_i    (fetchValid_i),
    .fetchMask_i     (fetchMask_i),
    .fetchPc_i       (fetchPc_i),
    .fetchInst_i     (fetchInst_i),
    .fetchReady_o    (fetchReady_o),
    .dispatchStall_i (dispatchStall_i),
    .dispatchReady_o (dispatchReady_o),
    .dispatchInst_o  (dispatchInst_o),
    .branchCount_o   (branchCount_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period.
  end

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("FAIL %s expected %h got %h", name, expVal, actVal);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic failWith(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  // one slot of a dispatched group against its expected fields.
  task automatic compareSlot(input integer slot, input integer base);
    got = dispatchInst_o[slot];
    checkValue("dispatchInst_o.pc", eField[expIdx][base], got.pc);
    checkValue("dispatchInst_o.opcode", eField[expIdx][base+1], 32'(got.opcode));
    checkValue("dispatchInst_o.dest", eField[expIdx][base+2], 32'(got.dest));
    checkValue("dispatchInst_o.src1", eField[expIdx][base+3], 32'(got.src1));
    checkValue("dispatchInst_o.src2", eField[expIdx][base+4], 32'(got.src2));
    checkValue("dispatchInst_o.imm", eField[expIdx][base+5], 32'(got.imm));
    checkValue("dispatchInst_o.isCti", eField[expIdx][base+6], 32'(got.isCti));
  endtask

  task automatic readStimulus();
    fd = $fopen("frontEnd_input.txt", "r");
    if (fd == 0) begin
      failWith("cannot open frontEnd_input.txt");
    end
    numLines = 0;
    numExp   = 0;
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        break;
      end
      if (kind == "B") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", bMask[numLines],
                       bPc[numLines], bWord[numLines][0], bWord[numLines][1],
                       bWord[numLines][2], bWord[numLines][3], bStall[numLines],
                       bFlush[numLines], bRnd[numLines], bGap[numLines]);
        numLines = numLines + 1;
      end else if (kind == "E") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       eField[numExp][0], eField[numExp][1], eField[numExp][2],
                       eField[numExp][3], eField[numExp][4], eField[numExp][5],
                       eField[numExp][6], eField[numExp][7], eField[numExp][8],
                       eField[numExp][9], eField[numExp][10], eField[numExp][11],
                       eField[numExp][12], eField[numExp][13], eField[numExp][14]);
        numExp = numExp + 1;
      end else begin
        code = $fgets(skipLine, fd);   // comment line.
      end
    end
    $fclose(fd);
  endtask

  initial begin
    arstN_i         = 1'b0;
    flush_i         = 1'b0;
    fetchValid_i    = 1'b0;
    fetchMask_i     = '0;
    fetchPc_i       = '0;
    fetchInst_i     = '0;
    dispatchStall_i = 1'b0;
    seed         = 32'he027;
    lineIdx      = 0;
    expIdx       = 0;
    gapLeft      = 0;
    stallLeft    = 0;
    cycles       = 0;
    lineActive   = 1'b0;
    stallLoaded  = 1'b0;
    rndNow       = 1'b0;
    sawBlock     = 1'b0;
    flushPending = 1'b0;
    running      = 1'b1;
    readStimulus();
    limit = 20 * (numLines + numExp) + 100;
    repeat (2) @(posedge clk);
    arstN_i <= 1'b1;   // reset held two cycles.

    while (running) begin
      @(posedge clk);
      flush_i <= 1'b0;
      if (gapLeft > 0) begin
        fetchValid_i <= 1'b0;   // idle cycle.
        lineActive = 1'b0;
        rndNow     = 1'b0;
        gapLeft    = gapLeft - 1;
      end else if (lineIdx < numLines) begin
        fetchValid_i <= (bMask[lineIdx] != 0);
        fetchMask_i  <= bMask[lineIdx][`FETCH_WIDTH-1:0];
        fetchPc_i    <= bPc[lineIdx];
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
          fetchInst_i[k] <= bWord[lineIdx][k];
        end
        flush_i <= bFlush[lineIdx][0];
        if (!stallLoaded && bStall[lineIdx] != 0) begin
          stallLeft = bStall[lineIdx];   // stall window opens.
        end
        stallLoaded = 1'b1;
        lineActive  = 1'b1;
        rndNow      = bRnd[lineIdx][0];
      end else begin
        fetchValid_i <= 1'b0;
        lineActive = 1'b0;
        rndNow     = 1'b0;
      end
      if (stallLeft > 0) begin
        dispatchStall_i <= 1'b1;
        stallLeft = stallLeft - 1;
      end else if (rndNow) begin
        dispatchStall_i <= $random(seed) & 1;
      end else begin
        dispatchStall_i <= 1'b0;
      end

      @(negedge clk);   // outputs settled here.
      cycles = cycles + 1;
      if (cycles > limit) begin
        failWith("timeout: dispatch stream did not complete in time");
      end
      if (!fetchReady_o) begin
        sawBlock = 1'b1;
      end
      if (flushPending) begin
        checkValue("dispatchReady_o", 32'd0, 32'(dispatchReady_o));
        flushPending = 1'b0;
      end
      if (flush_i) begin
        flushPending = 1'b1;   // checked one cycle later.
      end
      if (dispatchReady_o && !dispatchStall_i) begin
        if (expIdx >= numExp) begin
          failWith("a group was dispatched beyond the expected stream");
        end
        compareSlot(0, 0);
        compareSlot(1, 7);
        checkValue("branchCount_o", eField[expIdx][14], 32'(branchCount_o));
        expIdx = expIdx + 1;
      end
      if (lineActive && (!fetchValid_i || fetchReady_o)) begin
        gapLeft     = bGap[lineIdx];   // line taken this edge.
        lineIdx     = lineIdx + 1;
        stallLoaded = 1'b0;
      end
      running = (lineIdx < numLines) || (gapLeft > 0) || (expIdx < numExp);
    end

    // nothing left behind after the stream.
    repeat (4) begin
      @(negedge clk);
      if (dispatchReady_o) begin
        failWith("dispatchReady_o high after the expected stream ended");
      end
    end
    checkValue("fetchReady_o low during stall", 32'd1, 32'(sawBlock));
    if (expIdx == numExp) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "expected groups missing");
    end
  end

endmodule

`default_nettype wire

// ==== frontEnd_input.txt ====
# B mask pc w0 w1 w2 w3 stallCycles flush randomStall idleGap, all hex
# E pc op dest src1 src2 imm cti (slot 0, then slot 1) branchCount, all hex
B f 1000 00880004 1187fff0 40140008 23802010 0 0 0 0
B a 2000 deadbeef 50000020 deadbeef 40000030 0 0 0 0
B 1 3000 30000040 deadbeef deadbeef deadbeef 0 0 0 0
B 4 4000 deadbeef deadbeef 60000050 deadbeef 0 0 0 0
B f 5000 00000010 00000011 00000012 00000013 1e 0 0 0
B f 5010 00000014 00000015 00000016 00000017 0 0 0 0
B f 5020 00000018 00000019 0000001a 0000001b 0 0 0 0
B f 5030 0000001c 0000001d 0000001e 0000001f 0 0 0 0
B f 5040 00000020 00000021 00000022 00000023 0 0 0 e
B 1 6000 70000000 deadbeef deadbeef deadbeef 0 0 0 3
B f 6100 0000dead 0000beef 0000cafe 0000f00d 0 0 0 0
B 0 0 0 0 0 0 0 1 0 0
B 3 7000 5000ffff 00000001 deadbeef deadbeef 0 0 0 0
B f 8000 70000002 90000003 f0000004 10000005 0 0 1 0
B f 8010 40000006 50000007 20000008 60000009 0 0 1 0
E 1000 0 1 2 0 0004 0 1004 1 3 1 1f fff0 0 0
E 1008 4 0 5 0 0008 1 100c 2 7 0 1 2010 0 1
E 2004 5 0 0 0 0020 1 200c 4 0 0 0 0030 1 2
E 3000 3 0 0 0 0040 0 4008 6 0 0 0 0050 0 0
E 5000 0 0 0 0 0010 0 5004 0 0 0 0 0011 0 0
E 5008 0 0 0 0 0012 0 500c 0 0 0 0 0013 0 0
E 5010 0 0 0 0 0014 0 5014 0 0 0 0 0015 0 0
E 5018 0 0 0 0 0016 0 501c 0 0 0 0 0017 0 0
E 5020 0 0 0 0 0018 0 5024 0 0 0 0 0019 0 0
E 5028 0 0 0 0 001a 0 502c 0 0 0 0 001b 0 0
E 5030 0 0 0 0 001c 0 5034 0 0 0 0 001d 0 0
E 5038 0 0 0 0 001e 0 503c 0 0 0 0 001f 0 0
E 5040 0 0 0 0 0020 0 5044 0 0 0 0 0021 0 0
E 5048 0 0 0 0 0022 0 504c 0 0 0 0 0023 0 0
E 7000 5 0 0 7 ffff 1 7004 0 0 0 0 0001 0 1
E 8000 7 0 0 0 0002 0 8004 7 0 0 0 0003 0 0
E 8008 7 0 0 0 0004 0 800c 1 0 0 0 0005 0 0
E 8010 4 0 0 0 0006 1 8014 5 0 0 0 0007 1 2
E 8018 2 0 0 0 0008 0 801c 6 0 0 0 0009 0 0

// ==== frontEnd.f ====
+incdir+.
frontEndPkg.sv
multiPortRam.sv
instDecoder.sv
instBuffer.sv
frontEndTop.sv
tb_frontEnd.sv
